// ==== rtl/icache_macros.svh ====
//////////////////////////////
// geometry of the instruction cache
// address, line, fetch and set widths, way count
//////////////////////////////
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// physical fetch address
`define ICACHE_ADDR_W   16
// one fetched instruction word
`define ICACHE_FETCH_W  32
// full line, 4 fetch words
`define ICACHE_LINE_W   128
// byte offset inside a line
`define ICACHE_OFFSET_W 4

// set geometry
`define ICACHE_SETS     16
`define ICACHE_INDEX_W  4
// addr width minus index and offset
`define ICACHE_TAG_W    8

// associativity
`define ICACHE_WAYS     2
`define ICACHE_WAY_W    1

`endif

// ==== rtl/icache_mem_pkg.sv ====
//////////////////////////////
// address, line and word types
// refill request and return structs
//////////////////////////////
`default_nettype none

`include "icache_macros.svh"

package icache_mem_pkg;

  // basic address fields
  typedef logic [`ICACHE_ADDR_W-1:0]  paddr_t;
  typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;

  // payload types
  typedef logic [`ICACHE_LINE_W-1:0]  line_t;
  typedef logic [`ICACHE_FETCH_W-1:0] word_t;
  typedef logic [`ICACHE_WAY_W-1:0]   way_t;

  //////////////////////////////
  // refill port

  // line aligned address plus the way the line goes to
  typedef struct packed {
    paddr_t paddr;
    way_t   way;
  } refill_req_t;

  // whole line comes back in one beat
  typedef struct packed {
    line_t data;
  } refill_rtrn_t;

endpackage

`default_nettype wire

// ==== rtl/icache_ctrl_pkg.sv ====
//////////////////////////////
// controller states and array command
//////////////////////////////
`default_nettype none

package icache_ctrl_pkg;
  import icache_mem_pkg::*;

  // lookup controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  // one command per cycle to the tag/data arrays
  // rd reads all ways at index, result one cycle later
  // we writes tag, valid and line into way
  // clr drops the valid bits of every way at index
  typedef struct packed {
    logic   rd;
    logic   we;
    logic   clr;
    index_t index;
    tag_t   tag;
    way_t   way;
  } array_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/icache_ctrl.sv ====
//////////////////////////////
// lookup and refill FSM with flush counter
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl
  import icache_mem_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_ni,
  // fetch side
  input  wire               req_i,
  input  wire paddr_t       paddr_i,
  output logic              ready_o,
  output logic              valid_o,
  input  wire               flush_i,
  // from hit select
  input  wire               hit_i,
  input  wire way_t         victim_way_i,
  // refill side
  input  wire               mem_ack_i,
  input  wire               mem_rtrn_vld_i,
  output logic              mem_req_o,
  output refill_req_t       mem_req_data_o,
  output logic              miss_o,
  // to arrays and data path
  output array_cmd_t        cmd_o,
  output logic [`ICACHE_OFFSET_W-1:0] offset_q_o,
  output logic              fill_o
);

  ctrl_state_e state_d, state_q;
  logic        flush_d, flush_q;
  index_t      flush_cnt_q;
  paddr_t      paddr_q;
  logic        accept;
  logic        flush_done;

  // fetch handshake, ready and req at the same level
  assign accept     = ready_o & req_i;
  assign flush_done = (flush_cnt_q == index_t'(`ICACHE_SETS - 1));

  // word offset only, low byte bits are ignored
  assign offset_q_o = {paddr_q[`ICACHE_OFFSET_W-1:2], 2'b00};

  // line aligned refill address, way comes straight from the victim logic
  // array read data holds still until the next read so the way is stable
  assign mem_req_data_o.paddr = {paddr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                                 {`ICACHE_OFFSET_W{1'b0}}};
  assign mem_req_data_o.way   = victim_way_i;

  //////////////////////////////
  // main FSM
  always_comb begin
    state_d   = state_q;
    // latch incoming flush until it is served
    flush_d   = flush_q | flush_i;
    ready_o   = 1'b0;
    valid_o   = 1'b0;
    mem_req_o = 1'b0;
    miss_o    = 1'b0;
    fill_o    = 1'b0;

    unique case (state_q)
      // walk all sets and drop the valid bits
      FLUSH: begin
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      // wait for a fetch, pending flush goes first
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            state_d = READ;
          end
        end
      end
      // array data is here, compare result decides
      READ: begin
        if (hit_i) begin
          valid_o = 1'b1;
          if (flush_d) begin
            state_d = FLUSH;
          end else begin
            // back to back hits stream here
            ready_o = 1'b1;
            state_d = req_i ? READ : IDLE;
          end
        end else begin
          // hold the request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = MISS;
          end
        end
      end
      // return must be taken in the cycle it shows up
      MISS: begin
        fill_o = 1'b1;
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          state_d = flush_d ? FLUSH : IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  //////////////////////////////
  // array command
  always_comb begin
    cmd_o.rd    = accept;
    cmd_o.we    = (state_q == MISS) & mem_rtrn_vld_i;
    cmd_o.clr   = (state_q == FLUSH);
    cmd_o.tag   = paddr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    cmd_o.way   = victim_way_i;
    // flush counter, new fetch, or the held fetch for the line write
    if (state_q == FLUSH) begin
      cmd_o.index = flush_cnt_q;
    end else if (accept) begin
      cmd_o.index = paddr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    end else begin
      cmd_o.index = paddr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    end
  end

  // control regs, reset lands in FLUSH so the arrays start clean
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
      // wraps back to zero on the last set
      if (state_q == FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  // accepted fetch address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q <= paddr_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_arrays.sv ====
//////////////////////////////
// per way tag, valid and line storage
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_arrays
  import icache_mem_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire array_cmd_t                   cmd_i,
  input  wire line_t                        wline_i,
  output tag_t  [`ICACHE_WAYS-1:0]          tags_o,
  output logic  [`ICACHE_WAYS-1:0]          valids_o,
  output line_t [`ICACHE_WAYS-1:0]          lines_o
);

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    tag_t                    tag_mem  [`ICACHE_SETS];
    line_t                   data_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_q;
    logic                    way_we;
    tag_t                    tag_rd_q;
    line_t                   line_rd_q;
    logic                    valid_rd_q;

    // write only hits the commanded way
    assign way_we = cmd_i.we & (cmd_i.way == way_t'(w));

    // valid bits, clear beats write
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= '0;
      end else if (cmd_i.clr) begin
        valid_q[cmd_i.index] <= 1'b0;
      end else if (way_we) begin
        valid_q[cmd_i.index] <= 1'b1;
      end
    end

    // tag and line storage
    always_ff @(posedge clk_i) begin
      if (way_we) begin
        tag_mem[cmd_i.index]  <= cmd_i.tag;
        data_mem[cmd_i.index] <= wline_i;
      end
    end

    // synchronous read, output holds until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_rd_q <= 1'b0;
      end else if (cmd_i.rd) begin
        valid_rd_q <= valid_q[cmd_i.index];
      end
    end

    always_ff @(posedge clk_i) begin
      if (cmd_i.rd) begin
        tag_rd_q  <= tag_mem[cmd_i.index];
        line_rd_q <= data_mem[cmd_i.index];
      end
    end

    assign tags_o[w]   = tag_rd_q;
    assign valids_o[w] = valid_rd_q;
    assign lines_o[w]  = line_rd_q;
  end

endmodule

`default_nettype wire

// ==== rtl/icache_hit_select.sv ====
//////////////////////////////
// tag compare and fetch word select
// victim way choice with LFSR
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_hit_select
  import icache_mem_pkg::*;
(
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  wire tag_t  [`ICACHE_WAYS-1:0] tags_i,
  input  wire        [`ICACHE_WAYS-1:0] valids_i,
  input  wire line_t [`ICACHE_WAYS-1:0] lines_i,
  input  wire tag_t                     tag_i,
  input  wire [`ICACHE_OFFSET_W-1:0]    offset_i,
  input  wire                           fill_i,
  input  wire line_t                    rtrn_line_i,
  input  wire                           fill_we_i,
  output logic                          hit_o,
  output way_t                          victim_way_o,
  output word_t                         data_o
);

  logic [`ICACHE_WAYS-1:0] hit_vec;
  way_t                    hit_way;
  way_t                    inv_way;
  logic                    all_valid;
  logic [7:0]              lfsr_q;
  word_t                   hit_word;
  word_t                   fill_word;

  //////////////////////////////
  // tag compare
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_cmp
    assign hit_vec[w] = valids_i[w] & (tags_i[w] == tag_i);
  end

  assign hit_o = |hit_vec;

  // lowest hitting way, at most one is expected
  always_comb begin
    hit_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  // word out of the hit line, or straight from the refill line
  assign hit_word  = lines_i[hit_way][{offset_i, 3'b000} +: `ICACHE_FETCH_W];
  assign fill_word = rtrn_line_i[{offset_i, 3'b000} +: `ICACHE_FETCH_W];
  assign data_o    = fill_i ? fill_word : hit_word;

  //////////////////////////////
  // replacement

  // first invalid way from the bottom
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valids_i[w]) begin
        inv_way = way_t'(w);
      end
    end
  end

  assign all_valid    = &valids_i;
  assign victim_way_o = all_valid ? lfsr_q[`ICACHE_WAY_W-1:0] : inv_way;

  // galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
  // only moves when a random victim was actually used
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'h5a;
    end else if (fill_we_i && all_valid) begin
      lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hb8 : 8'h00);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
//////////////////////////////
// instruction cache top level
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_top
  import icache_mem_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_ni,
  input  wire               flush_i,
  output logic              miss_o,
  // fetch port
  input  wire               req_i,
  input  wire paddr_t       paddr_i,
  output logic              ready_o,
  output logic              valid_o,
  output word_t             data_o,
  // refill port
  output logic              mem_req_o,
  output refill_req_t       mem_req_data_o,
  input  wire               mem_ack_i,
  input  wire               mem_rtrn_vld_i,
  input  wire refill_rtrn_t mem_rtrn_i
);

  array_cmd_t                      cmd;
  tag_t  [`ICACHE_WAYS-1:0]        tags;
  logic  [`ICACHE_WAYS-1:0]        valids;
  line_t [`ICACHE_WAYS-1:0]        lines;
  logic                            hit;
  way_t                            victim_way;
  logic  [`ICACHE_OFFSET_W-1:0]    offset_q;
  logic                            fill;

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .paddr_i        (paddr_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .flush_i        (flush_i),
    .hit_i          (hit),
    .victim_way_i   (victim_way),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .miss_o         (miss_o),
    .cmd_o          (cmd),
    .offset_q_o     (offset_q),
    .fill_o         (fill)
  );

  // line write data comes straight off the return port
  icache_arrays u_arrays (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cmd_i    (cmd),
    .wline_i  (mem_rtrn_i.data),
    .tags_o   (tags),
    .valids_o (valids),
    .lines_o  (lines)
  );

  // request tag taken from the held refill address
  icache_hit_select u_hit_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tags_i       (tags),
    .valids_i     (valids),
    .lines_i      (lines),
    .tag_i        (mem_req_data_o.paddr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W]),
    .offset_i     (offset_q),
    .fill_i       (fill),
    .rtrn_line_i  (mem_rtrn_i.data),
    .fill_we_i    (cmd.we),
    .hit_o        (hit),
    .victim_way_o (victim_way),
    .data_o       (data_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
//////////////////////////////
// testbench clock and reset
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // free running clock, first rising edge half a period in
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset held over the first rising edges, released off the edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_icache.sv ====
//////////////////////////////
// testbench for the instruction cache
// memory model, directed and random fetches
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module tb_icache
  import icache_mem_pkg::*;
();

  localparam int          SETS         = `ICACHE_SETS;
  localparam int          N_RANDOM     = 40;
  // directed fetches on top of the random ones
  localparam int          N_FETCH      = N_RANDOM + 9;
  // reset flush plus one requested flush, and the reset itself
  localparam int          LIMIT_CYCLES = N_FETCH * 20 + 2 * (SETS + 1) + 8;
  localparam logic [15:0] SEED         = 16'd12;

  logic         clk_i;
  logic         rst_ni;
  logic         req_i;
  paddr_t       paddr_i;
  logic         ready_o;
  logic         valid_o;
  word_t        data_o;
  logic         flush_i;
  logic         miss_o;
  logic         mem_req_o;
  refill_req_t  mem_req_data_o;
  logic         mem_ack_i;
  logic         mem_rtrn_vld_i;
  refill_rtrn_t mem_rtrn_i;

  // one error count per process
  int           err_stim = 0;
  int           err_mem  = 0;
  int           err_mon  = 0;
  int           miss_cnt = 0;
  int           ack_cnt  = 0;
  int           refills  = 0;
  refill_req_t  last_req;
  logic [15:0]  stim_lfsr;
  logic [15:0]  mem_lfsr;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  icache_top u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .miss_o         (miss_o),
    .req_i          (req_i),
    .paddr_i        (paddr_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .data_o         (data_o),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_i     (mem_rtrn_i)
  );

  //////////////////////////////
  // random source and memory contents

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] galois_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one LFSR step per bit drawn
  function automatic int rand_bits(inout logic [15:0] s, input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(s[0]);
      s = galois_next(s);
    end
    return v;
  endfunction

  // every word is a fixed scramble of its own byte address
  function automatic word_t model_word(input paddr_t a);
    return ({16'h0, a} * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic line_t model_line(input paddr_t base);
    line_t line_data;
    for (int i = 0; i < 4; i++) begin
      line_data[i*32 +: 32] = model_word(paddr_t'(int'(base) + 4 * i));
    end
    return line_data;
  endfunction

  task automatic check(input logic cond, input string msg, inout int errs);
    assert (cond) else begin
      errs++;
      $display("FAIL %0t: %s", $time, msg);
    end
  endtask

  // cycles with ready low, sampled mid cycle
  task automatic count_not_ready(output int n);
    n = 0;
    @(negedge clk_i);
    while (!ready_o) begin
      n++;
      @(negedge clk_i);
    end
  endtask

  // one fetch, lat counts cycles from acceptance to valid
  task automatic fetch(input paddr_t addr, output int lat, output logic missed);
    word_t exp;
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    paddr_i = addr;
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    // taken at this edge
    @(posedge clk_i);
    #2;
    req_i  = 1'b0;
    lat    = 0;
    missed = 1'b0;
    do begin
      @(negedge clk_i);
      lat++;
      if (lat == 1) begin
        missed = mem_req_o;
      end
    end while (!valid_o);
    exp = model_word({addr[15:2], 2'b00});
    check(data_o == exp, $sformatf("data at %h is %h, expected %h", addr, data_o, exp),
          err_stim);
    if (missed) begin
      refills++;
      check(last_req.paddr == {addr[15:4], 4'h0},
            $sformatf("refill address %h for fetch at %h", last_req.paddr, addr), err_stim);
    end
  endtask

  //////////////////////////////
  // memory model, answers one refill at a time
  initial begin
    refill_req_t req;
    int          wait_cyc;
    mem_lfsr       = SEED;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i     = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o) begin
        req      = mem_req_data_o;
        last_req = req;
        // ack withheld 0 to 3 cycles, request has to stay put
        wait_cyc = rand_bits(mem_lfsr, 2);
        repeat (wait_cyc) begin
          @(negedge clk_i);
          check(mem_req_o && mem_req_data_o == req,
                $sformatf("refill request moved to %h before ack", mem_req_data_o), err_mem);
        end
        @(posedge clk_i);
        #2;
        mem_ack_i = 1'b1;
        @(posedge clk_i);
        #2;
        mem_ack_i = 1'b0;
        // line comes back 1 to 4 cycles after the ack
        wait_cyc = rand_bits(mem_lfsr, 2);
        repeat (wait_cyc) begin
          @(posedge clk_i);
          #2;
        end
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_i.data = model_line(req.paddr);
        @(posedge clk_i);
        #2;
        mem_rtrn_vld_i = 1'b0;
      end
    end
  end

  // miss pulse belongs to the ack cycle and nowhere else
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        check(miss_o == mem_ack_i, $sformatf("miss_o %b with ack %b", miss_o, mem_ack_i),
              err_mon);
        if (miss_o) begin
          miss_cnt++;
        end
        if (mem_ack_i) begin
          ack_cnt++;
        end
      end
    end
  end

  // watchdog
  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////
  // stimulus
  initial begin
    int     lat;
    int     n;
    logic   missed;
    way_t   a_way;
    way_t   b_way;
    way_t   c_way;
    paddr_t kept;
    paddr_t evicted;
    req_i     = 1'b0;
    paddr_i   = '0;
    flush_i   = 1'b0;
    stim_lfsr = SEED;

    // quiet while in reset, then one cycle per set of flushing
    @(negedge clk_i);
    check(!ready_o && !valid_o && !mem_req_o && !miss_o, "outputs not low in reset",
          err_stim);
    @(posedge rst_ni);
    count_not_ready(n);
    check(n == SETS, $sformatf("ready low %0d cycles after reset", n), err_stim);

    // miss then hit in the same line
    fetch(16'h1234, lat, missed);
    check(missed, "first fetch of a line raised no refill", err_stim);
    fetch(16'h123c, lat, missed);
    check(!missed && lat == 1, $sformatf("second fetch of a line took %0d cycles", lat),
          err_stim);

    // flush pulse, the cached line must be gone afterwards
    @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(negedge clk_i);
    check(!ready_o, "ready high while flush requested", err_stim);
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    count_not_ready(n);
    check(n == SETS, $sformatf("ready low %0d cycles for flush", n), err_stim);
    fetch(16'h1230, lat, missed);
    check(missed, "line still cached after flush", err_stim);

    // three lines into set 4, tags 20, 30 and 40
    fetch(16'h2040, lat, missed);
    check(missed, "line A hit in an empty set", err_stim);
    a_way = last_req.way;
    fetch(16'h3044, lat, missed);
    check(missed, "line B hit before refill", err_stim);
    b_way = last_req.way;
    fetch(16'h4048, lat, missed);
    check(missed, "line C hit before refill", err_stim);
    c_way = last_req.way;
    check(a_way == 1'b0 && b_way == 1'b1, "free ways not filled lowest first", err_stim);
    fetch(16'h404c, lat, missed);
    check(!missed && lat == 1, "line C does not hit after its refill", err_stim);
    // the line in the other way stays put
    kept = c_way ? 16'h2040 : 16'h3040;
    fetch(kept, lat, missed);
    check(!missed && lat == 1, $sformatf("line %h lost by the refill of C", kept), err_stim);
    // the replaced line has to come from memory again
    evicted = c_way ? 16'h3040 : 16'h2040;
    fetch(evicted, lat, missed);
    check(missed, $sformatf("replaced line %h still hits", evicted), err_stim);

    // random words over 64 lines, 4 tags per set
    repeat (N_RANDOM) begin
      fetch(16'h1000 + paddr_t'(rand_bits(stim_lfsr, 8) * 4), lat, missed);
    end

    @(negedge clk_i);
    check(miss_cnt == refills && ack_cnt == refills,
          $sformatf("%0d refills, %0d miss pulses, %0d acks", refills, miss_cnt, ack_cnt),
          err_stim);
    $display("errors: stimulus %0d, memory %0d, monitor %0d; refills %0d, acks %0d",
             err_stim, err_mem, err_mon, refills, ack_cnt);
    if (err_stim + err_mem + err_mon == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/icache_mem_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_ctrl.sv
rtl/icache_arrays.sv
rtl/icache_hit_select.sv
rtl/icache_top.sv
verif/tb_clk_gen.sv
verif/tb_icache.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_icache
FILELIST = verilog.f
OBJ_DIR  = obj_dir
PASS_MSG = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# output goes to the terminal, status comes from the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
